// ==== project.f ====
rtl/cpu_pkg.sv
rtl/bus_pkg.sv
rtl/mem_port_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/wb_master.sv
rtl/cpu_top.sv
sim/wb_memory_model.sv
sim/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module cpu_tb -o cpu_tb_sim

./obj_dir/cpu_tb_sim

// ==== sim/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*, bus_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic       clock, reset;
  logic       wb_cyc, wb_stb, wb_we, wb_ack;
  bus_addr_t  wb_adr;
  bus_data_t  wb_dat_w, wb_dat_r;
  logic       commit_valid, halted, illegal;
  reg_idx_t   commit_idx;
  reg_word_t  commit_data;
  logic [1:0] ack_delay;
  logic       random_acks;   // Zero delays when low
  logic [31:0] lcg_state;
  bus_addr_t  next_addr;     // Where the next instruction goes
  reg_idx_t   got_idx[$], exp_idx[$];
  reg_word_t  got_data[$], exp_data[$];

  cpu_top cpu_top_inst (
    .clock, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
    .wb_ack, .commit_valid, .commit_idx, .commit_data, .halted, .illegal
  );

  wb_memory_model mem_model (
    .clock, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack, .ack_delay
  );

  always #50 clock = ~clock;

  always @(posedge clock) begin
    #1;
    if (!wb_cyc) ack_delay = random_acks ? next_delay() : 2'd0;  // Only between cycles
  end

  function automatic logic [1:0] next_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16];
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic fail_stop();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      fail_stop();
    end
  endtask

  // Encodings, fields from the high bits down
  function automatic instr_t reg_form(opcode_e op, int rd, int ra, int rb);
    return {op, rd[2:0], ra[2:0], rb[2:0], 3'b000};
  endfunction

  function automatic instr_t imm_form(opcode_e op, int rd, int ra, int imm);
    return {op, rd[2:0], ra[2:0], imm[5:0]};
  endfunction

  task automatic start_program();
    mem_model.clear_all();
    next_addr = '0;
    exp_idx.delete();
    exp_data.delete();
  endtask

  task automatic put_instr(input instr_t word);
    mem_model.load_word(next_addr, word);
    next_addr = next_addr + 16'd1;
  endtask

  task automatic expect_commit(input int idx, input int data);
    exp_idx.push_back(idx[2:0]);
    exp_data.push_back(data[15:0]);
  endtask

  ////////////////////////////////////////
  // Reset, run, compare
  ////////////////////////////////////////
  task automatic apply_reset();
    @(posedge clock);
    #1 reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("wb_stb", wb_stb, 1'b0);
    check_flag("wb_we", wb_we, 1'b0);
    check_flag("commit_valid", commit_valid, 1'b0);
    check_flag("halted", halted, 1'b0);
    check_flag("illegal", illegal, 1'b0);
    @(posedge clock);
    #1 reset = 1'b0;
    @(posedge clock);
    @(negedge clock);
    check_flag("wb_cyc", wb_cyc, 1'b1);     // First fetch right away
    check_word("wb_adr", reg_word_t'(wb_adr), 16'h0000);
  endtask

  task automatic run_until_halt();
    int cycles;
    cycles = 0;
    got_idx.delete();
    got_data.delete();
    apply_reset();
    while (!halted) begin
      @(negedge clock);
      if (commit_valid) begin
        got_idx.push_back(commit_idx);
        got_data.push_back(commit_data);
      end
      cycles++;
      if (cycles > 3000) begin
        $display("timeout: halted did not rise within 3000 cycles");
        fail_stop();
      end
    end
  endtask

  task automatic compare_commits();
    check_word("commit count", reg_word_t'(got_idx.size()), reg_word_t'(exp_idx.size()));
    foreach (exp_idx[i]) begin
      check_idx("commit_idx", got_idx[i], exp_idx[i]);
      check_word("commit_data", got_data[i], exp_data[i]);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic load_alu_chain();
    start_program();
    put_instr(imm_form(OP_ADDI, 1, 0, 5));  expect_commit(1, 5);
    put_instr(imm_form(OP_ADDI, 2, 1, -3)); expect_commit(2, 2);  // EX/MEM forward
    put_instr(reg_form(OP_ADD, 3, 1, 2));   expect_commit(3, 7);  // WB and EX/MEM
    put_instr(reg_form(OP_SUB, 4, 3, 1));   expect_commit(4, 2);
    put_instr(reg_form(OP_AND, 5, 4, 3));   expect_commit(5, 2);
    put_instr(reg_form(OP_OR, 6, 5, 1));    expect_commit(6, 7);
    put_instr(imm_form(OP_ADDI, 7, 6, 31)); expect_commit(7, 38);
    put_instr(reg_form(OP_SUB, 1, 0, 7));   expect_commit(1, -38);
    put_instr(imm_form(OP_ADDI, 0, 1, 1));  // r0 write, no commit
    put_instr(reg_form(OP_OR, 2, 1, 0));    expect_commit(2, -38);
    put_instr(imm_form(OP_HALT, 0, 0, 0));
  endtask

  task automatic alu_chain();  // Zero delays, then random delays
    reg_idx_t  zero_idx[$];
    reg_word_t zero_data[$];
    random_acks = 1'b0;
    load_alu_chain();
    run_until_halt();
    compare_commits();
    zero_idx  = got_idx;
    zero_data = got_data;
    random_acks = 1'b1;
    load_alu_chain();
    run_until_halt();
    // Random delays must give the zero-delay trace
    check_word("commit count", reg_word_t'(got_idx.size()), reg_word_t'(zero_idx.size()));
    foreach (zero_idx[i]) begin
      check_idx("commit_idx", got_idx[i], zero_idx[i]);
      check_word("commit_data", got_data[i], zero_data[i]);
    end
  endtask

  task automatic store_then_load();
    start_program();
    put_instr(imm_form(OP_ADDI, 1, 0, 20)); expect_commit(1, 20);
    put_instr(imm_form(OP_ADDI, 2, 0, 13)); expect_commit(2, 13);
    put_instr(imm_form(OP_ST, 2, 1, 3));    // mem[23] = 13
    put_instr(imm_form(OP_LD, 3, 1, 3));    expect_commit(3, 13);
    put_instr(reg_form(OP_ADD, 4, 3, 2));   expect_commit(4, 26);  // Load-use
    put_instr(imm_form(OP_ST, 4, 1, 4));    // mem[24] = 26
    put_instr(imm_form(OP_LD, 5, 0, 24));   expect_commit(5, 26);
    put_instr(imm_form(OP_HALT, 0, 0, 0));
    run_until_halt();
    compare_commits();
    check_word("mem[23]", reg_word_t'(mem_model.peek(16'd23)), 16'd13);
    check_word("mem[24]", reg_word_t'(mem_model.peek(16'd24)), 16'd26);
  endtask

  task automatic branch_skip();
    start_program();
    put_instr(imm_form(OP_ADDI, 1, 0, 4));  expect_commit(1, 4);
    put_instr(imm_form(OP_ADDI, 2, 0, 4));  expect_commit(2, 4);
    put_instr(imm_form(OP_BEQ, 1, 2, 2));   // Taken, to 5
    put_instr(imm_form(OP_ADDI, 3, 0, 17)); // Marker
    put_instr(imm_form(OP_ADDI, 4, 0, 18)); // Marker
    put_instr(imm_form(OP_ADDI, 5, 0, 9));  expect_commit(5, 9);
    put_instr(imm_form(OP_BEQ, 5, 1, 1));   // 9 vs 4, falls through
    put_instr(imm_form(OP_ADDI, 6, 0, 10)); expect_commit(6, 10);
    put_instr(imm_form(OP_BEQ, 0, 0, 1));   // Taken, to 10
    put_instr(imm_form(OP_ADDI, 7, 0, 21)); // Marker
    put_instr(imm_form(OP_HALT, 0, 0, 0));
    run_until_halt();
    compare_commits();
  endtask

  task automatic halt_stops_bus();
    start_program();
    put_instr(imm_form(OP_ADDI, 1, 0, 1));  expect_commit(1, 1);
    put_instr(imm_form(OP_HALT, 0, 0, 0));
    put_instr(imm_form(OP_ADDI, 2, 0, 2));  // Never commits
    run_until_halt();
    compare_commits();
    check_flag("illegal", illegal, 1'b0);
    repeat (50) begin
      @(negedge clock);
      check_flag("wb_cyc", wb_cyc, 1'b0);
      check_flag("commit_valid", commit_valid, 1'b0);
    end
  endtask

  task automatic illegal_opcode();
    start_program();
    put_instr(imm_form(OP_ADDI, 1, 0, 3));  expect_commit(1, 3);
    put_instr(16'h9240);                    // Opcode 9 unassigned
    put_instr(imm_form(OP_ADDI, 2, 0, 4));
    run_until_halt();
    compare_commits();
    check_flag("illegal", illegal, 1'b1);
  endtask

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    ack_delay   = 2'd0;
    random_acks = 1'b1;
    lcg_state   = 32'd99520;
    alu_chain();
    store_then_load();
    branch_skip();
    halt_stops_bus();
    illegal_opcode();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== sim/wb_memory_model.sv ====
module wb_memory_model import bus_pkg::*; (
  input  logic       clock,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  bus_addr_t  wb_adr,
  input  bus_data_t  wb_dat_w,
  output bus_data_t  wb_dat_r,
  output logic       wb_ack,
  input  logic [1:0] ack_delay   // Extra wait cycles, changed only between bus cycles
);

  timeunit 1ns;
  timeprecision 100ps;

  bus_data_t  mem [1024];  // Upper address bits alias
  logic [1:0] wait_cnt;

  // Ack once the wait count reaches the delay, combinational read data
  assign wb_ack   = wb_cyc && wb_stb && (wait_cnt == ack_delay);
  assign wb_dat_r = mem[wb_adr[9:0]];

  always @(posedge clock) begin
    if (wb_cyc && wb_stb && !wb_ack) wait_cnt <= wait_cnt + 2'd1;
    else wait_cnt <= 2'd0;        // Idle or ack cycle
  end

  always @(posedge clock) begin
    if (wb_ack && wb_we) mem[wb_adr[9:0]] = wb_dat_w;  // Store lands on ack
  end

  ////////////////////////////////////////
  // Backdoor access
  ////////////////////////////////////////
  task automatic clear_all();
    for (int i = 0; i < 1024; i++) mem[i] = '0;  // All NOP
  endtask

  task automatic load_word(input bus_addr_t addr, input bus_data_t data);
    mem[addr[9:0]] = data;
  endtask

  function automatic bus_data_t peek(input bus_addr_t addr);
    return mem[addr[9:0]];
  endfunction

endmodule

// ==== rtl/cpu_top.sv ====
module cpu_top import cpu_pkg::*, bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output bus_addr_t wb_adr,
  output bus_data_t wb_dat_w,
  input  bus_data_t wb_dat_r,
  input  logic      wb_ack,
  output logic      commit_valid,
  output reg_idx_t  commit_idx,
  output reg_word_t commit_data,
  output logic      halted,
  output logic      illegal
);

  mem_port_if mem_port ();

  logic      redirect, load_use_stall;
  bus_addr_t branch_target;
  instr_t    if_id_instr;
  reg_word_t if_id_pc_next;
  logic      if_id_valid;
  ctrl_t     ex_ctrl, mem_ctrl;
  reg_idx_t  ex_rd, ex_ra, ex_rb, mem_rd;
  reg_word_t ex_a, ex_b, ex_imm, ex_pc_next;
  reg_word_t mem_result, mem_store_data;
  logic      ex_valid, mem_valid;

  ////////////////////////////////////////
  // Stages, writeback bundle is the commit trace
  ////////////////////////////////////////
  fetch_stage fetch_stage_inst (
    .clock, .reset, .advance(mem_port.advance), .redirect, .branch_target,
    .load_use_stall, .halted, .port(mem_port.fetch),
    .if_id_instr, .if_id_pc_next, .if_id_valid
  );

  decode_stage decode_stage_inst (
    .clock, .reset, .advance(mem_port.advance), .if_id_instr, .if_id_pc_next,
    .if_id_valid, .redirect, .wb_en(commit_valid), .wb_idx(commit_idx),
    .wb_data(commit_data), .load_use_stall, .ex_ctrl, .ex_rd, .ex_ra, .ex_rb,
    .ex_a, .ex_b, .ex_imm, .ex_pc_next, .ex_valid
  );

  execute_stage execute_stage_inst (
    .clock, .reset, .advance(mem_port.advance), .ex_ctrl, .ex_rd, .ex_ra, .ex_rb,
    .ex_a, .ex_b, .ex_imm, .ex_pc_next, .ex_valid, .wb_en(commit_valid),
    .wb_idx(commit_idx), .wb_data(commit_data), .redirect, .branch_target,
    .mem_ctrl, .mem_rd, .mem_result, .mem_store_data, .mem_valid
  );

  memory_stage memory_stage_inst (
    .clock, .reset, .advance(mem_port.advance), .mem_ctrl, .mem_rd, .mem_result,
    .mem_store_data, .mem_valid, .port(mem_port.data), .wb_en(commit_valid),
    .wb_idx(commit_idx), .wb_data(commit_data), .halted, .illegal
  );

  wb_master wb_master_inst (
    .clock, .reset, .halted, .port(mem_port.bus),
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

endmodule

// ==== rtl/wb_master.sv ====
module wb_master import bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      halted,
  mem_port_if.bus   port,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output bus_addr_t wb_adr,
  output bus_data_t wb_dat_w,
  input  bus_data_t wb_dat_r,
  input  logic      wb_ack
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e state;
  logic   want;

  assign want = !halted && (port.data_req || port.fetch_req);

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= ST_IDLE;
      wb_we  <= 1'b0;
    end else if (state == ST_IDLE && want) begin
      state <= ST_BUSY;
      wb_we <= port.data_req && port.data_we;   // Data side has priority
    end else if (state == ST_BUSY && wb_ack) begin
      state <= ST_IDLE;
      wb_we <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin  // Held until ack
    if (state == ST_IDLE && want) begin
      wb_adr   <= port.data_req ? port.data_addr : port.fetch_addr;
      wb_dat_w <= port.data_wdata;
    end
  end

  assign wb_cyc     = (state == ST_BUSY);
  assign wb_stb     = (state == ST_BUSY);
  assign port.rdata = wb_dat_r;
  // Step ends on ack, or at once with nothing to do
  assign port.advance = (state == ST_BUSY) ? wb_ack : (!halted && !want);

  // No bus cycle once halted
  assert property (@(posedge clock) disable iff (reset) halted |-> !wb_cyc);
  assert property (@(posedge clock) disable iff (reset)
                   wb_stb && !wb_ack |=> $stable(wb_adr));

endmodule

// ==== rtl/memory_stage.sv ====
module memory_stage import cpu_pkg::*, bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      advance,
  input  ctrl_t     mem_ctrl,
  input  reg_idx_t  mem_rd,
  input  reg_word_t mem_result,
  input  reg_word_t mem_store_data,
  input  logic      mem_valid,
  mem_port_if.data  port,
  output logic      wb_en,
  output reg_idx_t  wb_idx,
  output reg_word_t wb_data,
  output logic      halted,
  output logic      illegal
);

  logic wb_valid, wb_writes;

  // Data access straight from EX/MEM
  assign port.data_req   = mem_valid && (mem_ctrl.is_load || mem_ctrl.is_store);
  assign port.data_we    = mem_ctrl.is_store;
  assign port.data_addr  = bus_addr_t'(mem_result);
  assign port.data_wdata = bus_data_t'(mem_store_data);

  ////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
      wb_writes <= 1'b0;
      halted   <= 1'b0;
      illegal  <= 1'b0;
    end else if (advance) begin
      wb_valid  <= mem_valid;
      wb_writes <= mem_ctrl.writes_rd && mem_rd != ZERO_REG;
      if (mem_valid && (mem_ctrl.is_halt || mem_ctrl.is_illegal)) halted <= 1'b1;
      if (mem_valid && mem_ctrl.is_illegal) illegal <= 1'b1;  // Sticky
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      wb_idx  <= mem_rd;
      wb_data <= mem_ctrl.is_load ? reg_word_t'(port.rdata) : mem_result;
    end
  end

  // One pulse per committed write, at the end of the step
  assign wb_en = wb_valid && wb_writes && port.advance;

endmodule

// ==== rtl/execute_stage.sv ====
module execute_stage import cpu_pkg::*, bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      advance,
  input  ctrl_t     ex_ctrl,
  input  reg_idx_t  ex_rd,
  input  reg_idx_t  ex_ra,
  input  reg_idx_t  ex_rb,
  input  reg_word_t ex_a,
  input  reg_word_t ex_b,
  input  reg_word_t ex_imm,
  input  reg_word_t ex_pc_next,
  input  logic      ex_valid,
  input  logic      wb_en,
  input  reg_idx_t  wb_idx,
  input  reg_word_t wb_data,
  output logic      redirect,
  output bus_addr_t branch_target,
  output ctrl_t     mem_ctrl,
  output reg_idx_t  mem_rd,
  output reg_word_t mem_result,
  output reg_word_t mem_store_data,
  output logic      mem_valid
);

  reg_word_t opa, opb_reg, opb, alu_out;
  logic      mem_fwd_ok;

  // EX/MEM can forward unless it is a load
  assign mem_fwd_ok = mem_valid && mem_ctrl.writes_rd && !mem_ctrl.is_load &&
                      mem_rd != ZERO_REG;

  always_comb begin
    opa = ex_a;
    if (mem_fwd_ok && mem_rd == ex_ra)  opa = mem_result;
    else if (wb_en && wb_idx == ex_ra)  opa = wb_data;
  end

  always_comb begin
    opb_reg = ex_b;
    if (mem_fwd_ok && mem_rd == ex_rb)  opb_reg = mem_result;
    else if (wb_en && wb_idx == ex_rb)  opb_reg = wb_data;
  end

  assign opb = ex_ctrl.use_imm ? ex_imm : opb_reg;

  ////////////////////////////////////////
  // ALU and branch
  ////////////////////////////////////////
  always_comb begin
    case (ex_ctrl.alu_op)
      ALU_ADD: alu_out = opa + opb;
      ALU_SUB: alu_out = opa - opb;
      ALU_AND: alu_out = opa & opb;
      ALU_OR:  alu_out = opa | opb;
      default: alu_out = opb;          // Pass b
    endcase
  end

  assign branch_target = bus_addr_t'(ex_pc_next + ex_imm);  // PC + 1 + imm
  assign redirect      = ex_valid && ex_ctrl.is_branch && (opa == opb_reg);

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_ctrl  <= '0;
      mem_valid <= 1'b0;
    end else if (advance) begin
      mem_ctrl  <= ex_ctrl;
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      mem_rd         <= ex_rd;
      mem_result     <= alu_out;
      mem_store_data <= opb_reg;       // Forwarded rd value for ST
    end
  end

  // Taken branch leaves a bubble behind it
  assert property (@(posedge clock) disable iff (reset) redirect && advance |=> !ex_valid);

endmodule

// ==== rtl/decode_stage.sv ====
module decode_stage import cpu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      advance,
  input  instr_t    if_id_instr,
  input  reg_word_t if_id_pc_next,
  input  logic      if_id_valid,
  input  logic      redirect,
  input  logic      wb_en,
  input  reg_idx_t  wb_idx,
  input  reg_word_t wb_data,
  output logic      load_use_stall,
  output ctrl_t     ex_ctrl,
  output reg_idx_t  ex_rd,
  output reg_idx_t  ex_ra,
  output reg_idx_t  ex_rb,
  output reg_word_t ex_a,
  output reg_word_t ex_b,
  output reg_word_t ex_imm,
  output reg_word_t ex_pc_next,
  output logic      ex_valid
);

  reg_word_t regs [8];
  ctrl_t     ctrl;
  opcode_e   opc;
  reg_idx_t  rd, ra, rb_src;
  reg_word_t imm, a_val, b_val;
  logic      reads_ra;

  assign opc = opcode_e'(if_id_instr[OPC_MSB:OPC_LSB]);
  assign rd  = if_id_instr[RD_MSB:RD_LSB];
  assign ra  = if_id_instr[RA_MSB:RA_LSB];
  assign imm = {{10{if_id_instr[IMM_MSB]}}, if_id_instr[IMM_MSB:IMM_LSB]};
  // ST and BEQ take their second operand from rd
  assign rb_src = (opc == OP_ST || opc == OP_BEQ) ? rd : if_id_instr[RB_MSB:RB_LSB];

  ////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////
  always_comb begin
    ctrl = '0;  // Bubble
    if (if_id_valid) begin
      ctrl.alu_op = ALU_PASS_B;
      case (opc)
        OP_NOP:  ;
        OP_ADD:  begin ctrl.alu_op = ALU_ADD; ctrl.reads_rb = 1'b1; ctrl.writes_rd = 1'b1; end
        OP_SUB:  begin ctrl.alu_op = ALU_SUB; ctrl.reads_rb = 1'b1; ctrl.writes_rd = 1'b1; end
        OP_AND:  begin ctrl.alu_op = ALU_AND; ctrl.reads_rb = 1'b1; ctrl.writes_rd = 1'b1; end
        OP_OR:   begin ctrl.alu_op = ALU_OR;  ctrl.reads_rb = 1'b1; ctrl.writes_rd = 1'b1; end
        OP_ADDI: begin ctrl.alu_op = ALU_ADD; ctrl.use_imm = 1'b1; ctrl.writes_rd = 1'b1; end
        OP_LD: begin
          ctrl.alu_op    = ALU_ADD;            // Address = ra + imm
          ctrl.use_imm   = 1'b1;
          ctrl.writes_rd = 1'b1;
          ctrl.is_load   = 1'b1;
        end
        OP_ST: begin
          ctrl.alu_op   = ALU_ADD;
          ctrl.use_imm  = 1'b1;
          ctrl.reads_rb = 1'b1;                // Store data from rd
          ctrl.is_store = 1'b1;
        end
        OP_BEQ:  begin ctrl.reads_rb = 1'b1; ctrl.is_branch = 1'b1; end
        OP_HALT: ctrl.is_halt = 1'b1;
        default: ctrl.is_illegal = 1'b1;
      endcase
    end
  end

  assign reads_ra = ctrl.writes_rd || ctrl.is_store || ctrl.is_branch;

  // Register read, writeback bypassed in the same step
  always_comb begin
    a_val = regs[ra];
    b_val = regs[rb_src];
    if (wb_en && wb_idx == ra)     a_val = wb_data;
    if (wb_en && wb_idx == rb_src) b_val = wb_data;
    if (ra == ZERO_REG)            a_val = '0;
    if (rb_src == ZERO_REG)        b_val = '0;
  end

  always_ff @(posedge clock) begin
    if (wb_en && advance) regs[wb_idx] <= wb_data;
  end

  // Load in ID/EX feeding this instruction
  assign load_use_stall = ex_valid && ex_ctrl.is_load && ex_rd != ZERO_REG &&
                          ((reads_ra && ra == ex_rd) ||
                           (ctrl.reads_rb && rb_src == ex_rd));

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      ex_ctrl  <= '0;
      ex_valid <= 1'b0;
    end else if (advance) begin
      if (redirect || load_use_stall) begin
        ex_ctrl  <= '0;                        // Bubble
        ex_valid <= 1'b0;
      end else begin
        ex_ctrl  <= ctrl;
        ex_valid <= if_id_valid;
      end
    end
  end

  always_ff @(posedge clock) begin  // Payload
    if (advance) begin
      ex_rd      <= rd;
      ex_ra      <= ra;
      ex_rb      <= rb_src;
      ex_a       <= a_val;
      ex_b       <= b_val;
      ex_imm     <= imm;
      ex_pc_next <= if_id_pc_next;
    end
  end

  // Writeback never targets r0
  assert property (@(posedge clock) disable iff (reset) wb_en |-> wb_idx != ZERO_REG);

endmodule

// ==== rtl/fetch_stage.sv ====
module fetch_stage import cpu_pkg::*, bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      advance,
  input  logic      redirect,
  input  bus_addr_t branch_target,
  input  logic      load_use_stall,
  input  logic      halted,
  mem_port_if.fetch port,
  output instr_t    if_id_instr,
  output reg_word_t if_id_pc_next,
  output logic      if_id_valid
);

  bus_addr_t pc;
  logic      halt_seen;  // HALT passed into IF/ID, stop fetching
  instr_t    fetched;

  assign fetched         = instr_t'(port.rdata);
  assign port.fetch_addr = pc;
  assign port.fetch_req  = !halted && !halt_seen;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc            <= RESET_PC;
      halt_seen     <= 1'b0;
      if_id_instr   <= NOP_INSTR;
      if_id_pc_next <= '0;
      if_id_valid   <= 1'b0;
    end else if (advance) begin
      if (redirect) begin                 // Squash the wrong path
        pc          <= branch_target;
        halt_seen   <= 1'b0;              // A squashed HALT does not count
        if_id_instr <= NOP_INSTR;
        if_id_valid <= 1'b0;
      end else if (load_use_stall) begin
        // Hold PC and IF/ID
      end else if (port.data_req || !port.fetch_req) begin
        if_id_instr <= NOP_INSTR;         // Bus went to data, or fetch stopped
        if_id_valid <= 1'b0;
      end else begin
        pc            <= pc + 16'd1;
        if_id_instr   <= fetched;
        if_id_pc_next <= reg_word_t'(pc + 16'd1);
        if_id_valid   <= 1'b1;
        if (fetched[OPC_MSB:OPC_LSB] == OP_HALT) halt_seen <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/mem_port_if.sv ====
interface mem_port_if import bus_pkg::*; ();

  logic      fetch_req;   // Fetch side wants a word this step
  bus_addr_t fetch_addr;
  logic      data_req;    // Load or store pending in EX/MEM
  logic      data_we;
  bus_addr_t data_addr;
  bus_data_t data_wdata;
  bus_data_t rdata;       // Valid in the ack cycle
  logic      advance;     // End of a pipeline step

  // Fetch also watches data_req to see a data step
  modport fetch (output fetch_req, fetch_addr,
                 input  data_req, rdata, advance);

  modport data  (output data_req, data_we, data_addr, data_wdata,
                 input  rdata, advance);

  modport bus   (input  fetch_req, fetch_addr, data_req, data_we, data_addr, data_wdata,
                 output rdata, advance);

endinterface

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

  // Word addressed memory, one word per address
  typedef logic [15:0] bus_addr_t;
  typedef logic [15:0] bus_data_t;

  // Address of the first fetch after reset
  localparam bus_addr_t RESET_PC = '0;

endpackage

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [2:0]  reg_idx_t;   // Register index
  typedef logic [15:0] reg_word_t;  // Register / ALU value
  typedef logic [15:0] instr_t;     // Raw instruction word

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_ADDI = 4'd5,
    OP_LD   = 4'd6,
    OP_ST   = 4'd7,
    OP_BEQ  = 4'd8,
    OP_HALT = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_PASS_B = 3'd4
  } alu_op_e;

  // Decoded control, all zero means bubble
  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;     // Operand b is the immediate
    logic    reads_rb;    // Second source read (rb, or rd for ST/BEQ)
    logic    writes_rd;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    logic    is_halt;
    logic    is_illegal;
  } ctrl_t;

  localparam instr_t   NOP_INSTR = '0;
  localparam reg_idx_t ZERO_REG  = '0;

  ////////////////////////////////////////
  // Field positions, high bits down
  ////////////////////////////////////////
  localparam int OPC_MSB = 15;
  localparam int OPC_LSB = 12;
  localparam int RD_MSB  = 11;
  localparam int RD_LSB  = 9;
  localparam int RA_MSB  = 8;
  localparam int RA_LSB  = 6;
  localparam int RB_MSB  = 5;
  localparam int RB_LSB  = 3;
  localparam int IMM_MSB = 5;  // Signed 6-bit immediate
  localparam int IMM_LSB = 0;

endpackage
